//--- hw/sw_types_pkg.sv
`default_nettype none

package sw_types_pkg;

    // shared sram banks behind one write port
    parameter int NUM_SRAM = 32;

    // bank index into the status table
    typedef logic [4:0] sram_idx_t;

    // destination switch port of a descriptor
    typedef logic [3:0] port_t;

    // packet length in words
    typedef logic [8:0] pkt_len_t;

    // free words left in one bank
    // wider than a length so a full bank fits
    typedef logic [10:0] space_t;

    // packets currently held by a bank
    typedef logic [8:0] amount_t;

    // matcher scan tick, also used for the threshold
    typedef logic [4:0] tick_t;

endpackage

`default_nettype wire

//--- hw/sw_ctrl_pkg.sv
`default_nettype none

package sw_ctrl_pkg;

    // bank selection engine
    typedef enum logic [1:0] {
        // waiting for match_enable
        MATCH_IDLE = 2'd0,
        // walking the banks
        MATCH_SCAN = 2'd1,
        // match_suc cycle
        MATCH_DONE = 2'd2
    } match_state_e;

    // descriptor dispatcher
    typedef enum logic [1:0] {
        // queue watch
        DISP_IDLE  = 2'd0,
        // allocation pulse out, status table books it
        DISP_LOAD  = 2'd1,
        // match_enable held
        DISP_MATCH = 2'd2,
        // one idle cycle before the next pop
        DISP_GAP   = 2'd3
    } disp_state_e;

endpackage

`default_nettype wire

//--- hw/wr_request_fifo.sv
`default_nettype none
`timescale 1ns/1ps

module wr_request_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       push,
    input  wire sw_types_pkg::port_t    push_dest_port,
    input  wire sw_types_pkg::pkt_len_t push_length,
    input  wire                       pop,
    output sw_types_pkg::port_t         head_dest_port,
    output sw_types_pkg::pkt_len_t      head_length,
    output logic                      empty,
    output logic                      full,
    output logic                      drop
);
    import sw_types_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    // descriptor storage, no reset needed
    port_t    mem_port [FIFO_DEPTH];
    pkt_len_t mem_len  [FIFO_DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    // one extra bit so full and empty differ
    logic [AW:0]   count;

    logic do_push;
    logic do_pop;

    assign empty = (count == '0);
    assign full  = (count == (AW+1)'(FIFO_DEPTH));

    // a push while full is lost
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // show-ahead head entry
    assign head_dest_port = mem_port[rd_ptr];
    assign head_length    = mem_len[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_port[wr_ptr] <= push_dest_port;
            mem_len[wr_ptr]  <= push_length;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            drop   <= 1'b0;
        end else begin
            // pointers wrap on the power of two depth
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // one cycle drop strobe
            drop <= push && full;
        end
    end

    // dispatcher only pops a visible head
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!rst_n) !(pop && empty)
    );

endmodule

`default_nettype wire

//--- hw/sram_status_table.sv
`default_nettype none
`timescale 1ns/1ps

module sram_status_table (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         stat_wr,
    input  wire sw_types_pkg::sram_idx_t  stat_sram,
    input  wire                         stat_accessible,
    input  wire sw_types_pkg::space_t     stat_free_space,
    input  wire sw_types_pkg::amount_t    stat_packet_amount,
    input  wire                         scan_enable,
    output sw_types_pkg::sram_idx_t       matching_sram,
    output logic                        accessible,
    output sw_types_pkg::space_t          free_space,
    output sw_types_pkg::amount_t         packet_amount,
    input  wire                         alloc_valid,
    input  wire sw_types_pkg::sram_idx_t  alloc_sram,
    input  wire sw_types_pkg::pkt_len_t   alloc_length
);
    import sw_types_pkg::*;

    // per bank status
    logic    bank_acc  [NUM_SRAM];
    space_t  bank_free [NUM_SRAM];
    amount_t bank_amt  [NUM_SRAM];

    sram_idx_t scan_ptr;

    // scan pointer counts enable cycles
    // held at bank 0 between matches
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scan_ptr <= '0;
        end else if (!scan_enable) begin
            scan_ptr <= '0;
        end else begin
            // wraps through all 32 banks
            scan_ptr <= scan_ptr + 1'b1;
        end
    end

    // bank under the pointer, read straight out
    assign matching_sram = scan_ptr;
    assign accessible    = bank_acc[scan_ptr];
    assign free_space    = bank_free[scan_ptr];
    assign packet_amount = bank_amt[scan_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // all banks start closed and empty
            for (int i = 0; i < NUM_SRAM; i++) begin
                bank_acc[i]  <= 1'b0;
                bank_free[i] <= '0;
                bank_amt[i]  <= '0;
            end
        end else begin
            // book the granted packet
            if (alloc_valid) begin
                bank_free[alloc_sram] <= bank_free[alloc_sram] - space_t'(alloc_length);
                bank_amt[alloc_sram]  <= bank_amt[alloc_sram] + 1'b1;
            end
            // host write comes last, so it wins on the same bank
            if (stat_wr) begin
                bank_acc[stat_sram]  <= stat_accessible;
                bank_free[stat_sram] <= stat_free_space;
                bank_amt[stat_sram]  <= stat_packet_amount;
            end
        end
    end

    // matcher only picks banks that had room
    a_alloc_fits: assert property (
        @(posedge clk) disable iff (!rst_n)
        alloc_valid |-> (bank_free[alloc_sram] >= space_t'(alloc_length))
    );

endmodule

`default_nettype wire

//--- hw/port_wr_sram_matcher.sv
`default_nettype none
`timescale 1ns/1ps

module port_wr_sram_matcher (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire sw_types_pkg::tick_t      match_threshold,
    input  wire sw_types_pkg::port_t      new_dest_port,
    input  wire sw_types_pkg::pkt_len_t   new_length,
    input  wire                         match_enable,
    output logic                        match_suc,
    input  wire sw_types_pkg::sram_idx_t  matching_sram,
    output sw_types_pkg::sram_idx_t       matching_best_sram,
    output logic                        update_matched_sram,
    input  wire                         accessible,
    input  wire sw_types_pkg::space_t     free_space,
    input  wire sw_types_pkg::amount_t    packet_amount,
    output sw_ctrl_pkg::match_state_e     match_state
);
    import sw_types_pkg::*;
    import sw_ctrl_pkg::*;

    // running search state
    logic    matching_find;
    tick_t   matching_tick;
    amount_t max_amount;

    logic eligible;
    logic better;
    logic succeed;

    // bank must be open and hold the whole packet
    assign eligible = accessible && (free_space >= space_t'(new_length));
    // ties move to the later bank
    assign better   = eligible && (packet_amount >= max_amount);

    // threshold reached with a candidate in hand
    assign succeed  = (match_state == MATCH_SCAN) && matching_find &&
                      (matching_tick >= match_threshold);

    // best found, still waiting on the tick
    assign update_matched_sram = match_enable && !match_suc && matching_find;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            match_state <= MATCH_IDLE;
            match_suc   <= 1'b0;
        end else begin
            case (match_state)
                MATCH_IDLE: begin
                    if (match_enable) begin
                        match_state <= MATCH_SCAN;
                    end
                end
                MATCH_SCAN: begin
                    if (succeed) begin
                        match_suc   <= 1'b1;
                        match_state <= MATCH_DONE;
                    end else if (!match_enable) begin
                        // request withdrawn mid scan
                        match_state <= MATCH_IDLE;
                    end
                end
                MATCH_DONE: begin
                    // single cycle success pulse
                    match_suc   <= 1'b0;
                    match_state <= MATCH_IDLE;
                end
                default: begin
                    match_state <= MATCH_IDLE;
                end
            endcase
        end
    end

    // tick follows the scan pointer but sticks at 31
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            matching_tick <= '0;
        end else if (!match_enable) begin
            matching_tick <= '0;
        end else if (matching_tick != '1) begin
            matching_tick <= matching_tick + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            matching_find <= 1'b0;
            max_amount    <= '0;
        end else if (!match_enable || match_suc) begin
            matching_find <= 1'b0;
            max_amount    <= '0;
        end else if (better && !succeed) begin
            // bank under the pointer is the new best
            // frozen on the success edge so the result covers earlier banks only
            max_amount    <= packet_amount;
            matching_find <= 1'b1;
        end
    end

    // best index is payload, no reset
    always_ff @(posedge clk) begin
        if (match_enable && !match_suc && better && !succeed) begin
            matching_best_sram <= matching_sram;
        end
    end

    // success only after a candidate was latched into the best index
    a_suc_has_find: assert property (
        @(posedge clk) disable iff (!rst_n)
        match_suc |-> ($past(matching_find) && !$isunknown(matching_best_sram))
    );

    // dispatcher keeps the descriptor still for the whole scan
    a_desc_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (match_enable && $past(match_enable)) |->
            ($stable(new_dest_port) && $stable(new_length))
    );

endmodule

`default_nettype wire

//--- hw/wr_dispatch_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

module wr_dispatch_ctrl (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         empty,
    input  wire sw_types_pkg::port_t      head_dest_port,
    input  wire sw_types_pkg::pkt_len_t   head_length,
    output logic                        pop,
    output logic                        match_enable,
    output sw_types_pkg::port_t           new_dest_port,
    output sw_types_pkg::pkt_len_t        new_length,
    input  wire                         match_suc,
    input  wire sw_types_pkg::sram_idx_t  matching_best_sram,
    output logic                        alloc_valid,
    output sw_types_pkg::sram_idx_t       alloc_sram,
    output sw_types_pkg::port_t           alloc_dest_port,
    output sw_types_pkg::pkt_len_t        alloc_length
);
    import sw_types_pkg::*;
    import sw_ctrl_pkg::*;

    disp_state_e state;

    // take the head as soon as we are free
    assign pop = (state == DISP_IDLE) && !empty;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= DISP_IDLE;
            match_enable <= 1'b0;
            alloc_valid  <= 1'b0;
        end else begin
            // default low, pulses below
            alloc_valid <= 1'b0;
            case (state)
                DISP_IDLE: begin
                    if (!empty) begin
                        match_enable <= 1'b1;
                        state        <= DISP_MATCH;
                    end
                end
                DISP_MATCH: begin
                    if (match_suc) begin
                        // enable drops with the allocation pulse
                        match_enable <= 1'b0;
                        alloc_valid  <= 1'b1;
                        state        <= DISP_LOAD;
                    end
                end
                DISP_LOAD: begin
                    // status table books the bank this cycle
                    state <= DISP_GAP;
                end
                DISP_GAP: begin
                    state <= DISP_IDLE;
                end
                default: begin
                    state <= DISP_IDLE;
                end
            endcase
        end
    end

    // descriptor latched with the pop
    always_ff @(posedge clk) begin
        if (pop) begin
            new_dest_port <= head_dest_port;
            new_length    <= head_length;
        end
    end

    // allocation payload, held until the next grant
    always_ff @(posedge clk) begin
        if ((state == DISP_MATCH) && match_suc) begin
            alloc_sram      <= matching_best_sram;
            alloc_dest_port <= new_dest_port;
            alloc_length    <= new_length;
        end
    end

    // idle means the matcher is released
    a_idle_no_enable: assert property (
        @(posedge clk) disable iff (!rst_n) (state == DISP_IDLE) |-> !match_enable
    );

endmodule

`default_nettype wire

//--- hw/port_wr_frontend.sv
`default_nettype none
`timescale 1ns/1ps

module port_wr_frontend #(
    parameter int FIFO_DEPTH = 8
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         req_valid,
    input  wire sw_types_pkg::port_t      req_dest_port,
    input  wire sw_types_pkg::pkt_len_t   req_length,
    input  wire sw_types_pkg::tick_t      match_threshold,
    input  wire                         stat_wr,
    input  wire sw_types_pkg::sram_idx_t  stat_sram,
    input  wire                         stat_accessible,
    input  wire sw_types_pkg::space_t     stat_free_space,
    input  wire sw_types_pkg::amount_t    stat_packet_amount,
    output logic                        alloc_valid,
    output sw_types_pkg::sram_idx_t       alloc_sram,
    output sw_types_pkg::port_t           alloc_dest_port,
    output sw_types_pkg::pkt_len_t        alloc_length,
    output logic                        req_full,
    output logic                        req_drop
);
    import sw_types_pkg::*;

    // queue head to dispatcher
    port_t     head_dest_port;
    pkt_len_t  head_length;
    logic      empty;
    logic      pop;

    // dispatcher to matcher
    logic      match_enable;
    port_t     new_dest_port;
    pkt_len_t  new_length;
    logic      match_suc;
    sram_idx_t matching_best_sram;

    // status table read port
    sram_idx_t matching_sram;
    logic      accessible;
    space_t    free_space;
    amount_t   packet_amount;

    wr_request_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk            (clk),
        .rst_n          (rst_n),
        .push           (req_valid),
        .push_dest_port (req_dest_port),
        .push_length    (req_length),
        .pop            (pop),
        .head_dest_port (head_dest_port),
        .head_length    (head_length),
        .empty          (empty),
        .full           (req_full),
        .drop           (req_drop)
    );

    wr_dispatch_ctrl u_disp (
        .clk                (clk),
        .rst_n              (rst_n),
        .empty              (empty),
        .head_dest_port     (head_dest_port),
        .head_length        (head_length),
        .pop                (pop),
        .match_enable       (match_enable),
        .new_dest_port      (new_dest_port),
        .new_length         (new_length),
        .match_suc          (match_suc),
        .matching_best_sram (matching_best_sram),
        .alloc_valid        (alloc_valid),
        .alloc_sram         (alloc_sram),
        .alloc_dest_port    (alloc_dest_port),
        .alloc_length       (alloc_length)
    );

    // debug outputs of the matcher left open
    port_wr_sram_matcher u_match (
        .clk                 (clk),
        .rst_n               (rst_n),
        .match_threshold     (match_threshold),
        .new_dest_port       (new_dest_port),
        .new_length          (new_length),
        .match_enable        (match_enable),
        .match_suc           (match_suc),
        .matching_sram       (matching_sram),
        .matching_best_sram  (matching_best_sram),
        .update_matched_sram (),
        .accessible          (accessible),
        .free_space          (free_space),
        .packet_amount       (packet_amount),
        .match_state         ()
    );

    sram_status_table u_stat (
        .clk                (clk),
        .rst_n              (rst_n),
        .stat_wr            (stat_wr),
        .stat_sram          (stat_sram),
        .stat_accessible    (stat_accessible),
        .stat_free_space    (stat_free_space),
        .stat_packet_amount (stat_packet_amount),
        .scan_enable        (match_enable),
        .matching_sram      (matching_sram),
        .accessible         (accessible),
        .free_space         (free_space),
        .packet_amount      (packet_amount),
        .alloc_valid        (alloc_valid),
        .alloc_sram         (alloc_sram),
        .alloc_length       (alloc_length)
    );

endmodule

`default_nettype wire

//--- verification/tb_port_wr_frontend.sv
`default_nettype none
`timescale 1ns/1ps

module tb_port_wr_frontend;
    import sw_types_pkg::*;

    localparam int FIFO_DEPTH = 8;
    localparam int NUM_ROWS   = 12;
    // two directed sequences run after the table
    localparam int NUM_STEPS  = NUM_ROWS + 2;
    localparam int WATCHDOG_CYCLES = NUM_STEPS * 80 + 200;
    localparam int ALLOC_WAIT = 80;
    localparam int EXP_MODEL  = -1;
    localparam logic [31:0] RAND_SEED = 32'h28c5_eec4;

    // bank setup modes of a table row
    localparam int SETUP_ONLY7   = 0;
    localparam int SETUP_FULLEST = 1;
    localparam int SETUP_FILTER  = 2;
    localparam int SETUP_KEEP    = 3;
    localparam int SETUP_RANDOM  = 4;

    logic      clk;
    logic      rst_n;
    logic      req_valid;
    port_t     req_dest_port;
    pkt_len_t  req_length;
    tick_t     match_threshold;
    logic      stat_wr;
    sram_idx_t stat_sram;
    logic      stat_accessible;
    space_t    stat_free_space;
    amount_t   stat_packet_amount;
    logic      alloc_valid;
    sram_idx_t alloc_sram;
    port_t     alloc_dest_port;
    pkt_len_t  alloc_length;
    logic      req_full;
    logic      req_drop;

    // stimulus table, one row per step
    int row_mode [NUM_ROWS];
    int row_thr  [NUM_ROWS];
    int row_port [NUM_ROWS];
    int row_len  [NUM_ROWS];
    int row_exp  [NUM_ROWS];

    // reference copy of the bank records
    logic    m_acc  [NUM_SRAM];
    space_t  m_free [NUM_SRAM];
    amount_t m_amt  [NUM_SRAM];

    int value_errors;
    int other_errors;
    int drop_count;
    bit full_seen;

    port_wr_frontend #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_port_wr_frontend (
        .clk                (clk),
        .rst_n              (rst_n),
        .req_valid          (req_valid),
        .req_dest_port      (req_dest_port),
        .req_length         (req_length),
        .match_threshold    (match_threshold),
        .stat_wr            (stat_wr),
        .stat_sram          (stat_sram),
        .stat_accessible    (stat_accessible),
        .stat_free_space    (stat_free_space),
        .stat_packet_amount (stat_packet_amount),
        .alloc_valid        (alloc_valid),
        .alloc_sram         (alloc_sram),
        .alloc_dest_port    (alloc_dest_port),
        .alloc_length       (alloc_length),
        .req_full           (req_full),
        .req_drop           (req_drop)
    );

    always #5 clk = ~clk;

    // drop pulses and the full level, sampled mid cycle
    always @(negedge clk) begin
        if (rst_n && req_drop) begin
            drop_count++;
        end
        if (rst_n && req_full) begin
            full_seen = 1'b1;
        end
    end

    task automatic set_row(input int r, input int mode, input int thr, input int port,
                           input int len, input int exp);
        row_mode[r] = mode;
        row_thr[r]  = thr;
        row_port[r] = port;
        row_len[r]  = len;
        row_exp[r]  = exp;
    endtask

    task automatic check_sram(input sram_idx_t got, input sram_idx_t exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR @ %0t ns: %s bank %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_port(input port_t got, input port_t exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR @ %0t ns: %s port %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_len(input pkt_len_t got, input pkt_len_t exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR @ %0t ns: %s length %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    function automatic bit bank_fits(input int i, input int len);
        return m_acc[i] && (int'(m_free[i]) >= len);
    endfunction

    // c = max(threshold, first eligible + 1), fullest below c, ties to the later bank
    function automatic int predict_bank(input int thr, input int len);
        int first;
        int c;
        int best;
        amount_t best_amt;
        first = -1;
        best  = -1;
        best_amt = '0;
        for (int i = NUM_SRAM - 1; i >= 0; i--) begin
            if (bank_fits(i, len)) first = i;
        end
        if (first < 0) return -1;
        c = (thr > first + 1) ? thr : first + 1;
        for (int i = 0; i < c; i++) begin
            if (bank_fits(i, len) && (best < 0 || m_amt[i] >= best_amt)) begin
                best     = i;
                best_amt = m_amt[i];
            end
        end
        return best;
    endfunction

    // reference bookkeeping after a grant
    task automatic book_alloc(input int bank, input int len);
        m_free[bank] = m_free[bank] - space_t'(len);
        m_amt[bank]  = m_amt[bank] + 1'b1;
    endtask

    task automatic set_bank(input int i, input logic acc, input int free, input int amt);
        m_acc[i]  = acc;
        m_free[i] = space_t'(free);
        m_amt[i]  = amount_t'(amt);
    endtask

    // fill the reference records for one setup mode
    task automatic build_banks(input int mode);
        int forced;
        for (int i = 0; i < NUM_SRAM; i++) begin
            set_bank(i, 1'b0, 0, 0);
        end
        case (mode)
            SETUP_ONLY7: set_bank(7, 1'b1, 100, 3);
            SETUP_FULLEST: begin
                set_bank(2, 1'b1, 100, 5);
                set_bank(10, 1'b1, 100, 9);
                set_bank(20, 1'b1, 100, 9);
                // fullest, but beyond the threshold
                set_bank(31, 1'b1, 100, 50);
            end
            SETUP_FILTER: begin
                // closed bank
                set_bank(4, 1'b0, 500, 100);
                // open but too small
                set_bank(6, 1'b1, 10, 90);
                set_bank(12, 1'b1, 200, 2);
                set_bank(15, 1'b1, 200, 1);
            end
            SETUP_RANDOM: begin
                for (int i = 0; i < NUM_SRAM; i++) begin
                    set_bank(i, logic'($urandom % 2), $urandom % 2048, $urandom % 512);
                end
                // one roomy bank keeps the next few rows satisfiable
                forced = $urandom % NUM_SRAM;
                set_bank(forced, 1'b1, 2047, m_amt[forced]);
            end
            default: ;
        endcase
    endtask

    task automatic write_bank(input int i);
        @(posedge clk);
        #1;
        stat_wr            = 1'b1;
        stat_sram          = sram_idx_t'(i);
        stat_accessible    = m_acc[i];
        stat_free_space    = m_free[i];
        stat_packet_amount = m_amt[i];
        @(posedge clk);
        #1;
        stat_wr = 1'b0;
    endtask

    // copy all reference records into the DUT
    task automatic write_all_banks();
        for (int i = 0; i < NUM_SRAM; i++) begin
            write_bank(i);
        end
    endtask

    task automatic push_desc(input int port, input int len);
        @(posedge clk);
        #1;
        req_valid     = 1'b1;
        req_dest_port = port_t'(port);
        req_length    = pkt_len_t'(len);
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic wait_alloc(input int limit, output bit found);
        found = 1'b0;
        for (int n = 0; n < limit && !found; n++) begin
            @(negedge clk);
            if (alloc_valid) found = 1'b1;
        end
    endtask

    // wait for one grant and check it against the expectation
    task automatic expect_alloc(input int bank, input int port, input int len, input string what);
        bit found;
        wait_alloc(ALLOC_WAIT, found);
        if (!found) begin
            other_errors++;
            $display("%s: no allocation arrived within %0d cycles", what, ALLOC_WAIT);
        end else begin
            check_sram(alloc_sram, sram_idx_t'(bank), what);
            check_port(alloc_dest_port, port_t'(port), what);
            check_len(alloc_length, pkt_len_t'(len), what);
        end
        book_alloc(bank, len);
    endtask

    task automatic expect_quiet(input int cycles, input string what);
        bit found;
        wait_alloc(cycles, found);
        if (found) begin
            other_errors++;
            $display("%s: an allocation appeared that should not exist", what);
        end
    endtask

    task automatic run_row(input int r);
        int thr;
        int port;
        int len;
        int exp;
        int pred;
        if (row_mode[r] != SETUP_KEEP) begin
            build_banks(row_mode[r]);
            write_all_banks();
        end
        thr  = row_thr[r];
        port = row_port[r];
        len  = row_len[r];
        if (row_mode[r] == SETUP_RANDOM) begin
            thr  = $urandom % 32;
            port = $urandom % 16;
            len  = 1 + $urandom % 511;
        end
        pred = predict_bank(thr, len);
        exp  = (row_exp[r] == EXP_MODEL) ? pred : row_exp[r];
        if (pred != exp) begin
            other_errors++;
            $display("row %0d: reference model picks bank %0d, table says %0d", r, pred, exp);
        end
        if (exp < 0) begin
            other_errors++;
            $display("row %0d: no eligible bank, row skipped", r);
        end else begin
            match_threshold = tick_t'(thr);
            push_desc(port, len);
            expect_alloc(exp, port, len, $sformatf("row %0d", r));
        end
    endtask

    // nothing eligible, then one status write unblocks the scan
    task automatic run_stall();
        build_banks(SETUP_KEEP);
        write_all_banks();
        match_threshold = tick_t'(5);
        push_desc(2, 60);
        expect_quiet(60, "stall");
        set_bank(9, 1'b1, 300, 0);
        write_bank(9);
        expect_alloc(predict_bank(5, 60), 2, 60, "resume");
    endtask

    task automatic run_queue_full();
        int drops_before;
        build_banks(SETUP_KEEP);
        write_all_banks();
        match_threshold = tick_t'(0);
        // blocker occupies the dispatcher so the queue can fill
        push_desc(15, 8);
        repeat (3) @(posedge clk);
        drops_before = drop_count;
        full_seen    = 1'b0;
        for (int i = 1; i <= FIFO_DEPTH + 2; i++) begin
            @(posedge clk);
            #1;
            req_valid     = 1'b1;
            req_dest_port = port_t'(i);
            req_length    = pkt_len_t'(10 + i);
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        repeat (2) @(posedge clk);
        if (!full_seen) begin
            other_errors++;
            $display("queue: req_full never rose while the queue was stalled");
        end
        if (drop_count - drops_before != 2) begin
            other_errors++;
            $display("queue: expected 2 drop pulses, saw %0d", drop_count - drops_before);
        end
        set_bank(0, 1'b1, 2047, 0);
        write_bank(0);
        expect_alloc(predict_bank(0, 8), 15, 8, "blocker");
        // survivors come out in arrival order
        for (int i = 1; i <= FIFO_DEPTH; i++) begin
            expect_alloc(predict_bank(0, 10 + i), i, 10 + i, $sformatf("queued %0d", i));
        end
        expect_quiet(30, "queue tail");
    endtask

    initial begin
        int seed_ret;
        seed_ret = $urandom(RAND_SEED);
        clk                = 1'b0;
        rst_n              = 1'b0;
        req_valid          = 1'b0;
        req_dest_port      = '0;
        req_length         = '0;
        match_threshold    = '0;
        stat_wr            = 1'b0;
        stat_sram          = '0;
        stat_accessible    = 1'b0;
        stat_free_space    = '0;
        stat_packet_amount = '0;
        value_errors       = 0;
        other_errors       = 0;
        drop_count         = 0;
        full_seen          = 1'b0;

        // mode, threshold, port, length, expected bank
        set_row(0, SETUP_ONLY7, 0, 3, 40, 7);
        set_row(1, SETUP_FULLEST, 31, 5, 30, 20);
        set_row(2, SETUP_FILTER, 31, 9, 50, 12);
        set_row(3, SETUP_KEEP, 31, 10, 100, 12);
        // bank 12 drained below the length
        set_row(4, SETUP_KEEP, 31, 11, 100, 15);
        set_row(5, SETUP_RANDOM, 0, 0, 0, EXP_MODEL);
        set_row(6, SETUP_KEEP, 31, 1, 300, EXP_MODEL);
        set_row(7, SETUP_KEEP, 12, 4, 400, EXP_MODEL);
        set_row(8, SETUP_RANDOM, 0, 0, 0, EXP_MODEL);
        set_row(9, SETUP_RANDOM, 0, 0, 0, EXP_MODEL);
        set_row(10, SETUP_KEEP, 3, 7, 511, EXP_MODEL);
        set_row(11, SETUP_RANDOM, 0, 0, 0, EXP_MODEL);

        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        if (alloc_valid || req_drop || req_full) begin
            other_errors++;
            $display("reset: outputs not quiet after reset");
        end

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        run_stall();
        run_queue_full();

        $display("done: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // hard stop if the DUT never answers
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not complete", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
hw/sw_types_pkg.sv
hw/sw_ctrl_pkg.sv
hw/wr_request_fifo.sv
hw/sram_status_table.sv
hw/port_wr_sram_matcher.sv
hw/wr_dispatch_ctrl.sv
hw/port_wr_frontend.sv
verification/tb_port_wr_frontend.sv

//--- Bender.yml
package:
  name: port_wr_frontend

sources:
  - hw/sw_types_pkg.sv
  - hw/sw_ctrl_pkg.sv
  - hw/wr_request_fifo.sv
  - hw/sram_status_table.sv
  - hw/port_wr_sram_matcher.sv
  - hw/wr_dispatch_ctrl.sv
  - hw/port_wr_frontend.sv
  - target: test
    files:
      - verification/tb_port_wr_frontend.sv
